// ==== Bender.yml ====
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_line_merge.sv
  - dcache_arrays.sv
  - dcache_control.sv
  - dcache_word_select.sv
  - dcache.sv
  - target: test
    files:
      - dcache_tb.sv

// ==== dcache.f ====
dcache_pkg.sv
dcache_line_merge.sv
dcache_arrays.sv
dcache_control.sv
dcache_word_select.sv
dcache.sv
dcache_tb.sv

// ==== dcache.sv ====
`default_nettype none

module dcache
	import dcache_pkg::*;
#(
	parameter int num_sets = 8
)
(
	input  logic                   clk,
	input  logic                   reset,
	// ------------------------------
	// CPU side
	input  logic                   mem_read,
	input  logic                   mem_write,
	input  logic [addr_bits-1:0]   mem_address,
	input  logic [word_bits-1:0]   mem_wdata,
	input  logic [word_bits/8-1:0] mem_byte_enable,
	output logic                   mem_resp,
	output logic [word_bits-1:0]   mem_rdata,
	// ------------------------------
	// Memory side
	output logic                   pmem_read,
	output logic                   pmem_write,
	output logic [addr_bits-1:0]   pmem_address,
	output dcache_line_t           pmem_wdata,
	input  dcache_line_t           pmem_rdata,
	input  logic                   pmem_resp
);

	dcache_addr_t        addr;
	dcache_ctrl_t        ctrl;
	dcache_line_t        line_in;
	dcache_line_t        hit_line;
	dcache_line_t        victim_line;
	logic [tag_bits-1:0] victim_tag;
	logic                hit;
	logic                dirty;
	logic                pmem_addr_sel;

	assign addr = dcache_addr_t'(mem_address);
	assign pmem_wdata = victim_line;  // Only the victim is ever written back.

	dcache_line_merge line_merge (
		.mem_wdata       (mem_wdata),
		.mem_byte_enable (mem_byte_enable),
		.offset          (addr.offset),
		.hit_line        (hit_line),
		.pmem_rdata      (pmem_rdata),
		.ctrl            (ctrl),
		.line_in         (line_in)
	);

	dcache_arrays #(
		.num_sets (num_sets)
	) arrays (
		.clk         (clk),
		.reset       (reset),
		.addr        (addr),
		.ctrl        (ctrl),
		.line_in     (line_in),
		.hit         (hit),
		.dirty       (dirty),
		.victim_tag  (victim_tag),
		.hit_line    (hit_line),
		.victim_line (victim_line)
	);

	dcache_control control (
		.clk           (clk),
		.reset         (reset),
		.mem_read      (mem_read),
		.mem_write     (mem_write),
		.pmem_resp     (pmem_resp),
		.hit           (hit),
		.dirty         (dirty),
		.mem_resp      (mem_resp),
		.pmem_read     (pmem_read),
		.pmem_write    (pmem_write),
		.pmem_addr_sel (pmem_addr_sel),
		.ctrl          (ctrl)
	);

	dcache_word_select word_select (
		.addr          (addr),
		.victim_tag    (victim_tag),
		.hit_line      (hit_line),
		.pmem_addr_sel (pmem_addr_sel),
		.mem_rdata     (mem_rdata),
		.pmem_address  (pmem_address)
	);

endmodule : dcache

`default_nettype wire

// ==== dcache_arrays.sv ====
`default_nettype none

module dcache_arrays
	import dcache_pkg::*;
#(
	parameter int num_sets = 8
)
(
	input  logic                clk,
	input  logic                reset,
	input  dcache_addr_t        addr,
	input  dcache_ctrl_t        ctrl,
	input  dcache_line_t        line_in,
	output logic                hit,
	output logic                dirty,
	output logic [tag_bits-1:0] victim_tag,
	output dcache_line_t        hit_line,
	output dcache_line_t        victim_line
);

	localparam int num_ways = 2;

	// ------------------------------
	// Storage
	// ------------------------------
	logic [tag_bits-1:0] tag_mem [num_ways][num_sets];
	dcache_line_t        data_mem [num_ways][num_sets];
	logic [num_ways-1:0] valid [num_sets];
	logic [num_ways-1:0] dirty_bits [num_sets];
	logic [num_sets-1:0] lru;  // Each bit names the least recently used way of its set.

	logic [num_ways-1:0] way_hit;
	logic                hit_way;
	logic                victim_way;
	logic                write_way;

	// ------------------------------
	// Lookup
	// ------------------------------
	always_comb
	begin
		for (int w = 0; w < num_ways; w++)
			way_hit[w] = valid[addr.index][w] && (tag_mem[w][addr.index] == addr.tag);
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1];  // Only meaningful while hit is high.
	assign victim_way = lru[addr.index];
	assign write_way = hit ? hit_way : victim_way;  // A fill replaces the victim.

	// Control sees the hit way's dirty bit on a hit, the victim's on a miss.
	assign dirty = dirty_bits[addr.index][write_way];

	assign hit_line = data_mem[hit_way][addr.index];
	assign victim_line = data_mem[victim_way][addr.index];
	assign victim_tag = tag_mem[victim_way][addr.index];

	// ------------------------------
	// Tag and data writes
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (ctrl.load_tag)
			tag_mem[write_way][addr.index] <= addr.tag;
		if (ctrl.load_data)
			data_mem[write_way][addr.index] <= line_in;
	end

	// ------------------------------
	// Valid, dirty and LRU state
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < num_sets; s++)
			begin
				valid[s] <= '0;
				dirty_bits[s] <= '0;
			end
			lru <= '0;
		end
		else
		begin
			if (ctrl.load_valid)
				valid[addr.index][write_way] <= 1'b1;
			if (ctrl.set_dirty)
				dirty_bits[addr.index][write_way] <= 1'b1;
			else if (ctrl.clr_dirty)
				dirty_bits[addr.index][write_way] <= 1'b0;
			if (ctrl.load_lru)
				lru[addr.index] <= ~hit_way;  // The other way becomes the next victim.
		end
	end

	// ------------------------------
	// Checks
	// ------------------------------
	geometry_match: assert property (@(posedge clk) num_sets == 2 ** index_bits)
		else $error("num_sets %0d does not match index_bits %0d", num_sets, index_bits);

	// A tag may live in one way of a set only, or the fill picked the wrong way.
	single_way_hit: assert property (@(posedge clk) disable iff (reset)
		!(way_hit[0] && way_hit[1]))
		else $error("Tag hit in both ways of set %0d", addr.index);

	dirty_strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(ctrl.set_dirty && ctrl.clr_dirty))
		else $error("set_dirty and clr_dirty asserted together");

endmodule : dcache_arrays

`default_nettype wire

// ==== dcache_control.sv ====
`default_nettype none

module dcache_control
	import dcache_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         mem_read,
	input  logic         mem_write,
	input  logic         pmem_resp,
	input  logic         hit,
	input  logic         dirty,
	output logic         mem_resp,
	output logic         pmem_read,
	output logic         pmem_write,
	output logic         pmem_addr_sel,
	output dcache_ctrl_t ctrl
);

	dcache_state_e state;
	dcache_state_e next_state;
	logic          request;

	assign request = mem_read || mem_write;

	// ------------------------------
	// State actions
	// ------------------------------
	always_comb
	begin
		ctrl = '0;
		pmem_addr_sel = 1'b1;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		mem_resp = 1'b0;

		case (state)
			dcache_idle:
			begin
				if (hit && mem_read)
				begin
					ctrl.load_lru = 1'b1;
					mem_resp = 1'b1;
				end
				else if (hit && mem_write)
				begin
					ctrl.load_data = 1'b1;  // Merged write line goes back into the hit way.
					ctrl.data_in_sel = 1'b1;
					ctrl.set_dirty = !dirty;
					ctrl.load_lru = 1'b1;
					mem_resp = 1'b1;
				end
			end

			dcache_write_back:
			begin
				pmem_addr_sel = 1'b1;  // Victim line address.
				pmem_write = 1'b1;
				ctrl.clr_dirty = pmem_resp;
			end

			dcache_fill:
			begin
				pmem_addr_sel = 1'b0;  // Request line address.
				pmem_read = 1'b1;
				ctrl.load_tag = pmem_resp;
				ctrl.load_data = pmem_resp;
				ctrl.load_valid = pmem_resp;
				ctrl.clr_dirty = pmem_resp;
			end

			default:
			begin
			end
		endcase
	end

	// ------------------------------
	// Next state
	// ------------------------------
	always_comb
	begin
		next_state = state;
		case (state)
			dcache_idle:
			begin
				if (request && !hit)
					next_state = dirty ? dcache_write_back : dcache_fill;
			end

			dcache_write_back:
			begin
				if (pmem_resp)
					next_state = dcache_fill;
			end

			dcache_fill:
			begin
				if (pmem_resp)
					next_state = dcache_idle;  // The held request hits on the next cycle.
			end

			default:
				next_state = dcache_idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= dcache_idle;
		else
			state <= next_state;
	end

	// ------------------------------
	// Checks
	// ------------------------------
	pmem_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write high together");

endmodule : dcache_control

`default_nettype wire

// ==== dcache_line_merge.sv ====
`default_nettype none

module dcache_line_merge
	import dcache_pkg::*;
(
	input  logic [word_bits-1:0]     mem_wdata,
	input  logic [word_bits/8-1:0]   mem_byte_enable,
	input  logic [offset_bits-1:0]   offset,
	input  dcache_line_t             hit_line,
	input  dcache_line_t             pmem_rdata,
	input  dcache_ctrl_t             ctrl,
	output dcache_line_t             line_in
);

	logic [$clog2(words_per_line)-1:0] word_sel;

	assign word_sel = offset[offset_bits-1:2];  // Byte offset dropped to get the word.

	always_comb
	begin
		line_in = pmem_rdata;  // A fill takes the memory line unchanged.
		if (ctrl.data_in_sel)
		begin
			line_in = hit_line;
			for (int b = 0; b < word_bits / 8; b++)
			begin
				if (mem_byte_enable[b])
					line_in[word_sel * word_bits + b * 8 +: 8] = mem_wdata[b * 8 +: 8];
			end
		end
	end

endmodule : dcache_line_merge

`default_nettype wire

// ==== dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

	// ------------------------------
	// Geometry
	// ------------------------------
	localparam int addr_bits = 32;
	localparam int word_bits = 32;
	localparam int line_bytes = 32;
	localparam int offset_bits = 5;
	localparam int words_per_line = line_bytes / (word_bits / 8);
	localparam int line_bits = line_bytes * 8;
	localparam int index_bits = 3;  // The top's num_sets must be 2 ** index_bits.
	localparam int tag_bits = addr_bits - index_bits - offset_bits;

	// ------------------------------
	// Types
	// ------------------------------
	typedef logic [line_bits-1:0] dcache_line_t;

	typedef struct packed {
		logic [tag_bits-1:0]    tag;
		logic [index_bits-1:0]  index;
		logic [offset_bits-1:0] offset;
	} dcache_addr_t;

	// Array strobes from the controller.
	typedef struct packed {
		logic load_lru;     // Mark the accessed way as most recent.
		logic load_tag;
		logic load_valid;
		logic load_data;
		logic data_in_sel;  // 1 selects merged CPU write data, 0 the memory line.
		logic set_dirty;
		logic clr_dirty;
	} dcache_ctrl_t;

	typedef enum logic [1:0] {
		dcache_idle,
		dcache_write_back,
		dcache_fill
	} dcache_state_e;

endpackage : dcache_pkg

`default_nettype wire

// ==== dcache_tb.sv ====
`default_nettype none

module dcache_tb
	import dcache_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_sets = 8;
	localparam int num_tags = 4;  // Four tags over two ways keep the sets conflicting.
	localparam int mem_lines = num_tags * num_sets;
	localparam int mem_bytes = mem_lines * line_bytes;
	localparam int num_requests = 2000;
	localparam int resp_timeout = 200;

	logic                   clk = 1'b0;
	logic                   reset;
	logic                   mem_read;
	logic                   mem_write;
	logic [addr_bits-1:0]   mem_address;
	logic [word_bits-1:0]   mem_wdata;
	logic [word_bits/8-1:0] mem_byte_enable;
	logic                   mem_resp;
	logic [word_bits-1:0]   mem_rdata;
	logic                   pmem_read;
	logic                   pmem_write;
	logic [addr_bits-1:0]   pmem_address;
	dcache_line_t           pmem_wdata;
	dcache_line_t           pmem_rdata;
	logic                   pmem_resp;

	logic                   resp_q = 1'b0;  // Outputs as seen at the rising edge.
	logic [word_bits-1:0]   rdata_q = '0;
	logic [31:0]            rng;
	int                     mem_delay = 0;
	int                     checks = 0;
	int                     errors = 0;
	logic                   timed_out = 1'b0;

	// ------------------------------
	// Reference model and memory
	// ------------------------------
	dcache_line_t           backing [mem_lines];
	logic [7:0]             model_mem [mem_bytes];
	logic [tag_bits-1:0]    m_tag [2][num_sets];
	logic                   m_valid [2][num_sets];
	logic                   m_dirty [2][num_sets];
	logic                   m_lru [num_sets];  // Least recently used way of each set.
	logic                   op_q [$];  // The pmem_write level of each memory transaction.
	logic [addr_bits-1:0]   addr_q [$];
	dcache_line_t           data_q [$];

	always #4 clk = ~clk;

	dcache #(
		.num_sets (num_sets)
	) UUT (
		.clk             (clk),
		.reset           (reset),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.mem_address     (mem_address),
		.mem_wdata       (mem_wdata),
		.mem_byte_enable (mem_byte_enable),
		.mem_resp        (mem_resp),
		.mem_rdata       (mem_rdata),
		.pmem_read       (pmem_read),
		.pmem_write      (pmem_write),
		.pmem_address    (pmem_address),
		.pmem_wdata      (pmem_wdata),
		.pmem_rdata      (pmem_rdata),
		.pmem_resp       (pmem_resp)
	);

	always @(posedge clk)
	begin
		resp_q <= mem_resp;
		rdata_q <= mem_rdata;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};  // Every address bit shows up.
	endfunction

	function automatic dcache_line_t model_line(input int base);
		dcache_line_t l;
		for (int b = 0; b < line_bytes; b++)
			l[b * 8 +: 8] = model_mem[base + b];
		return l;
	endfunction

	task automatic check_value(input string name, input logic [line_bits-1:0] got,
		input logic [line_bits-1:0] expected);
		checks++;
		assert (got === expected)
		else
		begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, expected);
		end
	endtask

	// ------------------------------
	// Memory responder
	// ------------------------------
	initial
	begin
		int wait_cycles;
		int line;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		forever
		begin
			@(negedge clk);
			if (!reset && (pmem_read || pmem_write))
			begin
				wait_cycles = mem_delay;
				for (int d = 0; d < wait_cycles; d++)
					@(negedge clk);
				line = pmem_address[offset_bits +: 5];
				pmem_resp = 1'b1;
				if (pmem_write)
					backing[line] = pmem_wdata;
				else
					pmem_rdata = backing[line];
				op_q.push_back(pmem_write);
				addr_q.push_back(pmem_address);
				data_q.push_back(pmem_wdata);
				@(negedge clk);
				pmem_resp = 1'b0;
			end
		end
	end

	// Called on a falling edge; returns on the falling edge after mem_resp.
	task automatic run_request(input logic write, input logic [31:0] address,
		input logic [31:0] wdata, input logic [3:0] be);
		dcache_addr_t a;
		int           way;
		logic         predicted_hit;
		logic         expect_wb;
		logic [31:0]  wb_address;
		dcache_line_t wb_line;
		int           base;
		int           n;
		int           cycles;

		a = dcache_addr_t'(address);
		base = {address[9:2], 2'b00};
		way = -1;
		expect_wb = 1'b0;
		for (int w = 0; w < 2; w++)
			if (m_valid[w][a.index] && m_tag[w][a.index] == a.tag)
				way = w;
		predicted_hit = (way >= 0);
		if (!predicted_hit)
		begin
			way = m_lru[a.index];
			expect_wb = m_dirty[way][a.index];
			if (expect_wb)
			begin
				wb_address = {m_tag[way][a.index], a.index, {offset_bits{1'b0}}};
				wb_line = model_line(wb_address[9:0]);
			end
		end

		op_q.delete();
		addr_q.delete();
		data_q.delete();
		mem_read = !write;
		mem_write = write;
		mem_address = address;
		mem_wdata = wdata;
		mem_byte_enable = be;

		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (resp_q !== 1'b1 && cycles < resp_timeout);
		mem_read = 1'b0;
		mem_write = 1'b0;
		if (resp_q !== 1'b1)
		begin
			timed_out = 1'b1;
			$display("No mem_resp within %0d cycles for address %h at %0t ns, state %s",
				resp_timeout, address, $time, UUT.control.state.name());
			return;
		end

		n = predicted_hit ? 0 : (expect_wb ? 2 : 1);
		check_value("pmem transaction count", op_q.size(), n);
		if (op_q.size() == n && n > 0)
		begin
			if (expect_wb)
			begin
				check_value("pmem_write", op_q[0], 1'b1);
				check_value("pmem_address", addr_q[0], wb_address);
				check_value("pmem_wdata", data_q[0], wb_line);
			end
			check_value("pmem_write", op_q[n-1], 1'b0);  // The last one must be the fill.
			check_value("pmem_address", addr_q[n-1], {address[31:5], 5'b0});
		end

		if (!write)
			check_value("mem_rdata", rdata_q,
				{model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]});

		if (!predicted_hit)
		begin
			m_valid[way][a.index] = 1'b1;
			m_tag[way][a.index] = a.tag;
			m_dirty[way][a.index] = 1'b0;
		end
		if (write)
		begin
			m_dirty[way][a.index] = 1'b1;
			for (int b = 0; b < 4; b++)
				if (be[b])
					model_mem[base + b] = wdata[b * 8 +: 8];
		end
		m_lru[a.index] = (way == 0);
	endtask

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial
	begin
		logic       dirty_copy;
		int         set_idx;
		logic [31:0] wdata;

		reset = 1'b1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		mem_byte_enable = '0;
		rng = 32'd60125;
		for (int l = 0; l < mem_lines; l++)
			for (int w = 0; w < words_per_line; w++)
				backing[l][w * 32 +: 32] = fill_word(l * line_bytes + w * 4);
		for (int a = 0; a < mem_bytes; a++)
			model_mem[a] = fill_word(a & ~3) >> ((a % 4) * 8);
		for (int s = 0; s < num_sets; s++)
		begin
			m_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++)
			begin
				m_valid[w][s] = 1'b0;
				m_dirty[w][s] = 1'b0;
			end
		end

		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (3)
		begin
			@(negedge clk);
			check_value("mem_resp", mem_resp, 1'b0);
			check_value("pmem_read", pmem_read, 1'b0);
			check_value("pmem_write", pmem_write, 1'b0);
		end

		for (int i = 0; i < num_requests && !timed_out; i++)
		begin
			rng = xorshift(rng);
			mem_delay = rng[15:13] % 6;
			wdata = xorshift(rng ^ 32'h3c5a);
			run_request(rng[0], {22'd0, rng[2:1], rng[5:3], rng[8:6], 2'b00}, wdata, rng[12:9]);
		end

		// Sweep every line, then compare memory for lines that hold no dirty copy.
		for (int l = 0; l < mem_lines && !timed_out; l++)
			for (int w = 0; w < words_per_line && !timed_out; w++)
			begin
				mem_delay = (l + w) % 6;
				run_request(1'b0, 32'(l * line_bytes + w * 4), '0, '0);
			end
		for (int l = 0; l < mem_lines && !timed_out; l++)
		begin
			dirty_copy = 1'b0;
			set_idx = l % num_sets;
			for (int w = 0; w < 2; w++)
				if (m_valid[w][set_idx] && m_dirty[w][set_idx] && m_tag[w][set_idx] == l / num_sets)
					dirty_copy = 1'b1;
			if (!dirty_copy)
				check_value("backing line", backing[l], model_line(l * line_bytes));
		end

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
		if (errors == 0 && !timed_out)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule : dcache_tb

`default_nettype wire

// ==== dcache_word_select.sv ====
`default_nettype none

module dcache_word_select
	import dcache_pkg::*;
(
	input  dcache_addr_t          addr,
	input  logic [tag_bits-1:0]   victim_tag,
	input  dcache_line_t          hit_line,
	input  logic                  pmem_addr_sel,
	output logic [word_bits-1:0]  mem_rdata,
	output logic [addr_bits-1:0]  pmem_address
);

	logic [$clog2(words_per_line)-1:0] word_sel;
	logic [tag_bits-1:0]               line_tag;

	assign word_sel = addr.offset[offset_bits-1:2];
	assign mem_rdata = hit_line[word_sel * word_bits +: word_bits];

	// Write-back goes to the victim's line, a fill to the requested line.
	assign line_tag = pmem_addr_sel ? victim_tag : addr.tag;
	assign pmem_address = {line_tag, addr.index, {offset_bits{1'b0}}};

endmodule : dcache_word_select

`default_nettype wire
